// File: trace_consts.svh
/*
 * Widths, table depths and CSR addresses of the commit trace monitor.
 * TRC_ROB_DEPTH must equal 2**TRC_OPID_W and TRC_TAG_NUM must equal 2**TRC_TAG_W.
 * Store sizes are kept in four bits, so TRC_STRB_W may not exceed 15.
 */
`ifndef TRC_CONSTS_SVH
`define TRC_CONSTS_SVH

`define TRC_XLEN        64
`define TRC_OPID_W      4
`define TRC_ROB_DEPTH   16
`define TRC_TAG_W       3
`define TRC_TAG_NUM     8
`define TRC_STRB_W      8
`define TRC_CSR_W       12
`define TRC_CNT_W       32

// supervisor aliases, reported at machine address
`define TRC_CSR_SSTATUS 12'h100
`define TRC_CSR_SIE     12'h104
`define TRC_CSR_SIP     12'h144
`define TRC_CSR_SUP_OFS 12'h200

// user counter aliases, cycle to instret
`define TRC_CSR_CYCLE   12'hc00
`define TRC_CSR_INSTRET 12'hc02
`define TRC_CSR_USR_OFS 12'h100

`endif

// File: perf_pkg.sv
/*
 * Event types seen by the performance counters and the store tracker.
 */
package perf_pkg;

    // kind of a back-end misprediction
    typedef enum logic [1:0] {
        MIS_BRANCH = 2'd0,
        MIS_JAL    = 2'd1,
        MIS_JALR   = 2'd2
    } mispred_e;

    // operation of a data cache response
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

endpackage

// File: trace_pkg.sv
/*
 * Types of the commit trace: operation id, CSR snapshot and CSR aliases.
 * The snapshot only holds mstatus, mtvec, mepc and mcause.
 */
`include "trace_consts.svh"

package trace_pkg;

    typedef logic [`TRC_OPID_W-1:0] opid_t;    // rob operation id

    // state before the committed instruction
    typedef struct packed {
        logic [`TRC_XLEN-1:0] mstatus;
        logic [`TRC_XLEN-1:0] mtvec;
        logic [`TRC_XLEN-1:0] mepc;
        logic [`TRC_XLEN-1:0] mcause;
    } csr_snap_t;

    // addresses rewritten on the CSR write path
    typedef enum logic [`TRC_CSR_W-1:0] {
        CSR_SSTATUS = `TRC_CSR_SSTATUS,
        CSR_SIE     = `TRC_CSR_SIE,
        CSR_SIP     = `TRC_CSR_SIP,
        CSR_CYCLE   = `TRC_CSR_CYCLE,
        CSR_INSTRET = `TRC_CSR_INSTRET
    } csr_addr_e;

endpackage

// File: mem_evt_if.sv
/*
 * One store memory change event, valid for a single cycle, no back-pressure.
 */
`include "trace_consts.svh"

interface mem_evt_if;

    logic                 valid;
    logic [3:0]           size;    // bytes written
    logic [`TRC_XLEN-1:0] addr;
    logic [`TRC_XLEN-1:0] data;    // aligned to lowest strobe byte

    modport store_tracker (output valid, size, addr, data);
    modport commit_trace (input valid, size, addr, data);

endinterface

// File: csr_snap_table.sv
/*
 * CSR snapshots indexed by operation id, written at decode, read at commit.
 * A read returns a snapshot from the cycle after its write onward.
 * Writing and reading the same id in one cycle is not supported.
 */
`include "trace_consts.svh"

module csr_snap_table (
    input  logic                clk,
    input  logic                dec_valid,
    input  trace_pkg::opid_t    dec_opid,
    input  trace_pkg::csr_snap_t dec_snap,
    input  trace_pkg::opid_t    rd_opid,
    output trace_pkg::csr_snap_t rd_snap,
    input  logic                rd_en
);

    trace_pkg::csr_snap_t snap_mem [`TRC_ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            snap_mem[dec_opid] <= dec_snap;    // state seen at decode
        end
    end

    assign rd_snap = snap_mem[rd_opid];    // combinational commit lookup

    // a commit may only read a snapshot stored in an earlier cycle
    a_no_rw_collision: assert property (
        @(posedge clk) rd_en && dec_valid |-> dec_opid != rd_opid
    ) else $error("snapshot of opid %0h written and read in one cycle", rd_opid);

endmodule

// File: store_tracker.sv
/*
 * Keeps address, aligned data and byte count per data cache request tag.
 * A response must come at least one cycle after the request of its tag.
 * Only a store response without a miss raises a memory change event.
 */
`include "trace_consts.svh"

module store_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rqst_valid,
    input  logic [`TRC_TAG_W-1:0] rqst_tag,
    input  logic [`TRC_XLEN-1:0]  rqst_addr,
    input  logic [`TRC_XLEN-1:0]  rqst_wdata,
    input  logic [`TRC_STRB_W-1:0] rqst_strb,
    input  logic                  resp_valid,
    input  logic [`TRC_TAG_W-1:0] resp_tag,
    input  perf_pkg::mem_op_e     resp_op,
    input  logic                  resp_miss,
    mem_evt_if.store_tracker      evt
);

    localparam int OFS_W = $clog2(`TRC_STRB_W);

    logic [`TRC_XLEN-1:0] st_addr [`TRC_TAG_NUM];
    logic [`TRC_XLEN-1:0] st_data [`TRC_TAG_NUM];
    logic [3:0]           st_size [`TRC_TAG_NUM];
    logic [`TRC_TAG_NUM-1:0] st_vld;
    logic [OFS_W-1:0]     strb_ofs;

    // index of the lowest set strobe bit
    always_comb begin
        strb_ofs = '0;
        for (int i = `TRC_STRB_W - 1; i >= 0; i--) begin
            if (rqst_strb[i]) strb_ofs = OFS_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rqst_valid) begin
            st_addr[rqst_tag] <= rqst_addr;
            st_data[rqst_tag] <= rqst_wdata >> {strb_ofs, 3'b000};    // shift out low bytes
            st_size[rqst_tag] <= 4'($countones(rqst_strb));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_vld <= '0;
        end else begin
            if (resp_valid && !resp_miss) st_vld[resp_tag] <= 1'b0;    // missed ones get replayed
            if (rqst_valid) st_vld[rqst_tag] <= 1'b1;
        end
    end

    assign evt.valid = resp_valid && resp_op == perf_pkg::MEM_STORE && !resp_miss;
    assign evt.size  = st_size[resp_tag];
    assign evt.addr  = st_addr[resp_tag];
    assign evt.data  = st_data[resp_tag];

    a_resp_has_rqst: assert property (
        @(posedge clk) disable iff (rst) resp_valid |-> st_vld[resp_tag]
    ) else $error("response on tag %0d without an open request", resp_tag);

endmodule

// File: commit_trace.sv
/*
 * Registered commit trace, one lane, every output one cycle after its strobe.
 * CSR writes to supervisor and user counter aliases show machine addresses.
 * Payload outputs hold their last value while the matching strobe is low.
 */
`include "trace_consts.svh"

module commit_trace (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmt_valid,
    input  trace_pkg::opid_t      cmt_opid,
    input  logic [`TRC_XLEN-1:0]  cmt_pc,
    input  logic [31:0]           cmt_ir,
    output trace_pkg::opid_t      snap_opid,
    input  trace_pkg::csr_snap_t  snap,
    input  logic                  csr_we,
    input  logic [`TRC_CSR_W-1:0] csr_addr,
    input  logic [`TRC_XLEN-1:0]  csr_wdata,
    mem_evt_if.commit_trace       evt,
    output logic                  trc_valid,
    output logic [`TRC_XLEN-1:0]  trc_pc,
    output logic [31:0]           trc_ir,
    output trace_pkg::csr_snap_t  trc_csr,
    output logic                  del_csrw,
    output logic [`TRC_CSR_W-1:0] del_csra,
    output logic [`TRC_XLEN-1:0]  del_csrv,
    output logic [3:0]            del_memw,
    output logic [`TRC_XLEN-1:0]  del_mema,
    output logic [`TRC_XLEN-1:0]  del_memv
);

    logic [`TRC_CSR_W-1:0] csr_norm;

    assign snap_opid = cmt_opid;    // lookup in the snapshot table

    always_comb begin
        csr_norm = csr_addr;
        if (csr_addr == trace_pkg::CSR_SSTATUS || csr_addr == trace_pkg::CSR_SIE ||
            csr_addr == trace_pkg::CSR_SIP) begin
            csr_norm = csr_addr + `TRC_CSR_SUP_OFS;    // sstatus, sie, sip
        end else if (csr_addr >= trace_pkg::CSR_CYCLE && csr_addr <= trace_pkg::CSR_INSTRET) begin
            csr_norm = csr_addr - `TRC_CSR_USR_OFS;    // cycle, time, instret
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trc_valid <= 1'b0;
            del_csrw  <= 1'b0;
            del_memw  <= '0;
        end else begin
            trc_valid <= cmt_valid;
            del_csrw  <= csr_we;
            del_memw  <= evt.valid ? evt.size : 4'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmt_valid) begin
            trc_pc  <= cmt_pc;
            trc_ir  <= cmt_ir;
            trc_csr <= snap;    // state before this instruction
        end
        if (csr_we) begin
            del_csra <= csr_norm;
            del_csrv <= csr_wdata;
        end
        if (evt.valid) begin
            del_mema <= evt.addr;
            del_memv <= evt.data;
        end
    end

endmodule

// File: perf_counters.sv
/*
 * Event counters, each one cycle behind its strobe, wrapping at TRC_CNT_W bits.
 * A front-end redirect is not counted in a cycle with a back-end misprediction.
 */
`include "trace_consts.svh"

module perf_counters (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mis_valid,
    input  perf_pkg::mispred_e    mis_kind,
    input  logic                  fe_redir,
    input  logic                  resp_valid,
    input  perf_pkg::mem_op_e     resp_op,
    input  logic                  ic_miss,
    input  logic                  dc_miss,
    input  logic                  itlb_fill,
    input  logic                  dtlb_fill,
    output logic [`TRC_CNT_W-1:0] bmisp,
    output logic [`TRC_CNT_W-1:0] brmisp,
    output logic [`TRC_CNT_W-1:0] jmisp,
    output logic [`TRC_CNT_W-1:0] jrmisp,
    output logic [`TRC_CNT_W-1:0] fmisp,
    output logic [`TRC_CNT_W-1:0] loads,
    output logic [`TRC_CNT_W-1:0] stores,
    output logic [`TRC_CNT_W-1:0] icmiss,
    output logic [`TRC_CNT_W-1:0] dcmiss,
    output logic [`TRC_CNT_W-1:0] itmiss,
    output logic [`TRC_CNT_W-1:0] dtmiss
);

    logic [10:0]                   inc;
    logic [10:0][`TRC_CNT_W-1:0]   cnt;

    always_comb begin
        inc[0]  = mis_valid;
        inc[1]  = mis_valid && mis_kind == perf_pkg::MIS_BRANCH;
        inc[2]  = mis_valid && mis_kind == perf_pkg::MIS_JAL;
        inc[3]  = mis_valid && mis_kind == perf_pkg::MIS_JALR;
        inc[4]  = fe_redir && !mis_valid;    // back-end flush wins
        inc[5]  = resp_valid && resp_op == perf_pkg::MEM_LOAD;
        inc[6]  = resp_valid && resp_op == perf_pkg::MEM_STORE;
        inc[7]  = ic_miss;
        inc[8]  = dc_miss;
        inc[9]  = itlb_fill;
        inc[10] = dtlb_fill;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < 11; i++) begin
                if (inc[i]) cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign {dtmiss, itmiss, dcmiss, icmiss, stores, loads} = cnt[10:5];
    assign {fmisp, jrmisp, jmisp, brmisp, bmisp} = cnt[4:0];

    // every back-end misprediction has exactly one known kind
    a_kind_sum: assert property (
        @(posedge clk) disable iff (rst) brmisp + jmisp + jrmisp == bmisp
    ) else $error("misprediction kinds do not add up to bmisp");

endmodule

// File: commit_monitor.sv
/*
 * Commit trace monitor beside an out-of-order core, one commit lane.
 * All inputs are single-cycle strobes, every output lags its strobe by one cycle.
 * dc_resp_store selects store (1) or load (0); mis_kind 3 is not a valid kind.
 */
`include "trace_consts.svh"

module commit_monitor (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dec_valid,
    input  logic [`TRC_OPID_W-1:0] dec_opid,
    input  logic [`TRC_XLEN-1:0]   dec_mstatus,
    input  logic [`TRC_XLEN-1:0]   dec_mtvec,
    input  logic [`TRC_XLEN-1:0]   dec_mepc,
    input  logic [`TRC_XLEN-1:0]   dec_mcause,
    input  logic                   cmt_valid,
    input  logic [`TRC_OPID_W-1:0] cmt_opid,
    input  logic [`TRC_XLEN-1:0]   cmt_pc,
    input  logic [31:0]            cmt_ir,
    input  logic                   csr_we,
    input  logic [`TRC_CSR_W-1:0]  csr_addr,
    input  logic [`TRC_XLEN-1:0]   csr_wdata,
    input  logic                   dc_rqst_valid,
    input  logic [`TRC_TAG_W-1:0]  dc_rqst_tag,
    input  logic [`TRC_XLEN-1:0]   dc_addr,
    input  logic [`TRC_XLEN-1:0]   dc_wdat,
    input  logic [`TRC_STRB_W-1:0] dc_strb,
    input  logic                   dc_resp_valid,
    input  logic [`TRC_TAG_W-1:0]  dc_resp_tag,
    input  logic                   dc_resp_store,
    input  logic                   dc_resp_miss,
    input  logic                   mis_valid,
    input  logic [1:0]             mis_kind,
    input  logic                   fe_redir,
    input  logic                   ic_miss,
    input  logic                   dc_miss,
    input  logic                   itlb_fill,
    input  logic                   dtlb_fill,
    output logic                   trc_valid,
    output logic [`TRC_XLEN-1:0]   trc_pc,
    output logic [31:0]            trc_ir,
    output logic [`TRC_XLEN-1:0]   trc_mstatus,
    output logic [`TRC_XLEN-1:0]   trc_mtvec,
    output logic [`TRC_XLEN-1:0]   trc_mepc,
    output logic [`TRC_XLEN-1:0]   trc_mcause,
    output logic                   del_csrw,
    output logic [`TRC_CSR_W-1:0]  del_csra,
    output logic [`TRC_XLEN-1:0]   del_csrv,
    output logic [3:0]             del_memw,
    output logic [`TRC_XLEN-1:0]   del_mema,
    output logic [`TRC_XLEN-1:0]   del_memv,
    output logic [`TRC_CNT_W-1:0]  bmisp,
    output logic [`TRC_CNT_W-1:0]  brmisp,
    output logic [`TRC_CNT_W-1:0]  jmisp,
    output logic [`TRC_CNT_W-1:0]  jrmisp,
    output logic [`TRC_CNT_W-1:0]  fmisp,
    output logic [`TRC_CNT_W-1:0]  loads,
    output logic [`TRC_CNT_W-1:0]  stores,
    output logic [`TRC_CNT_W-1:0]  icmiss,
    output logic [`TRC_CNT_W-1:0]  dcmiss,
    output logic [`TRC_CNT_W-1:0]  itmiss,
    output logic [`TRC_CNT_W-1:0]  dtmiss
);

    trace_pkg::csr_snap_t dec_snap;
    trace_pkg::csr_snap_t cmt_snap;
    trace_pkg::csr_snap_t trc_csr;
    trace_pkg::opid_t     snap_opid;
    perf_pkg::mem_op_e    resp_op;

    mem_evt_if mem_evt ();

    assign dec_snap = '{mstatus: dec_mstatus, mtvec: dec_mtvec, mepc: dec_mepc,
                        mcause: dec_mcause};
    assign {trc_mstatus, trc_mtvec, trc_mepc, trc_mcause} = trc_csr;
    assign resp_op  = perf_pkg::mem_op_e'(dc_resp_store);

    csr_snap_table snap_table_inst (
        .clk       (clk),
        .dec_valid (dec_valid),
        .dec_opid  (trace_pkg::opid_t'(dec_opid)),
        .dec_snap  (dec_snap),
        .rd_opid   (snap_opid),
        .rd_snap   (cmt_snap),
        .rd_en     (cmt_valid)
    );

    store_tracker store_tracker_inst (
        .clk        (clk),
        .rst        (rst),
        .rqst_valid (dc_rqst_valid),
        .rqst_tag   (dc_rqst_tag),
        .rqst_addr  (dc_addr),
        .rqst_wdata (dc_wdat),
        .rqst_strb  (dc_strb),
        .resp_valid (dc_resp_valid),
        .resp_tag   (dc_resp_tag),
        .resp_op    (resp_op),
        .resp_miss  (dc_resp_miss),
        .evt        (mem_evt)
    );

    commit_trace commit_trace_inst (
        .clk       (clk),
        .rst       (rst),
        .cmt_valid (cmt_valid),
        .cmt_opid  (trace_pkg::opid_t'(cmt_opid)),
        .cmt_pc    (cmt_pc),
        .cmt_ir    (cmt_ir),
        .snap_opid (snap_opid),
        .snap      (cmt_snap),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .evt       (mem_evt),
        .trc_valid (trc_valid),
        .trc_pc    (trc_pc),
        .trc_ir    (trc_ir),
        .trc_csr   (trc_csr),
        .del_csrw  (del_csrw),
        .del_csra  (del_csra),
        .del_csrv  (del_csrv),
        .del_memw  (del_memw),
        .del_mema  (del_mema),
        .del_memv  (del_memv)
    );

    perf_counters perf_counters_inst (
        .clk        (clk),
        .rst        (rst),
        .mis_valid  (mis_valid),
        .mis_kind   (perf_pkg::mispred_e'(mis_kind)),
        .fe_redir   (fe_redir),
        .resp_valid (dc_resp_valid),
        .resp_op    (resp_op),
        .ic_miss    (ic_miss),
        .dc_miss    (dc_miss),
        .itlb_fill  (itlb_fill),
        .dtlb_fill  (dtlb_fill),
        .bmisp      (bmisp),
        .brmisp     (brmisp),
        .jmisp      (jmisp),
        .jrmisp     (jrmisp),
        .fmisp      (fmisp),
        .loads      (loads),
        .stores     (stores),
        .icmiss     (icmiss),
        .dcmiss     (dcmiss),
        .itmiss     (itmiss),
        .dtmiss     (dtmiss)
    );

endmodule

// File: commit_monitor_tb.sv
/*
 * Self-checking testbench of the commit trace monitor.
 * The model runs on the rising edge and the checks sample on the falling edge.
 * Store responses only go to tags with an open request, as the DUT requires.
 */
`include "trace_consts.svh"

module commit_monitor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int N_SNAP = 8;
    localparam int N_CSR = 12;
    localparam int N_MEM = 12;
    localparam int N_PERF = 200;
    localparam int TEST_CYCLES = RST_CYCLES + 3 + 2 * N_SNAP + 2 + N_CSR + 2 + 3 * N_MEM + 2
                                 + N_PERF + 2;
    localparam int MARGIN = 100;
    localparam logic [11:0] CSR_LIST [N_CSR] = '{12'h100, 12'h104, 12'h144, 12'hc00, 12'hc01,
        12'hc02, 12'h300, 12'hbff, 12'hc03, 12'h105, 12'h000, 12'hfff};

    logic clk = 1'b0;
    logic rst;
    logic dec_valid, cmt_valid, csr_we, dc_rqst_valid, dc_resp_valid, dc_resp_store;
    logic dc_resp_miss, mis_valid, fe_redir, ic_miss, dc_miss, itlb_fill, dtlb_fill;
    logic [`TRC_OPID_W-1:0] dec_opid, cmt_opid;
    logic [`TRC_XLEN-1:0] dec_mstatus, dec_mtvec, dec_mepc, dec_mcause, cmt_pc;
    logic [`TRC_XLEN-1:0] csr_wdata, dc_addr, dc_wdat;
    logic [31:0] cmt_ir;
    logic [`TRC_CSR_W-1:0] csr_addr;
    logic [`TRC_TAG_W-1:0] dc_rqst_tag, dc_resp_tag;
    logic [`TRC_STRB_W-1:0] dc_strb;
    logic [1:0] mis_kind;
    logic trc_valid, del_csrw;
    logic [`TRC_XLEN-1:0] trc_pc, trc_mstatus, trc_mtvec, trc_mepc, trc_mcause;
    logic [`TRC_XLEN-1:0] del_csrv, del_mema, del_memv;
    logic [31:0] trc_ir;
    logic [`TRC_CSR_W-1:0] del_csra;
    logic [3:0] del_memw;
    logic [`TRC_CNT_W-1:0] bmisp, brmisp, jmisp, jrmisp, fmisp, loads, stores;
    logic [`TRC_CNT_W-1:0] icmiss, dcmiss, itmiss, dtmiss;

    trace_pkg::csr_snap_t snap_mdl [`TRC_ROB_DEPTH];    // values given at decode
    trace_pkg::csr_snap_t exp_snap;
    logic [`TRC_XLEN-1:0] rec_addr [`TRC_TAG_NUM];
    logic [`TRC_XLEN-1:0] rec_data [`TRC_TAG_NUM];
    logic [3:0] rec_size [`TRC_TAG_NUM];
    logic exp_trc_valid, exp_csrw, exp_mem_evt;
    logic [`TRC_XLEN-1:0] exp_pc, exp_csrv, exp_mema, exp_memv;
    logic [31:0] exp_ir;
    logic [`TRC_CSR_W-1:0] exp_csra;
    logic [3:0] exp_memw;
    logic [10:0][`TRC_CNT_W-1:0] exp_cnt;
    logic [10:0][`TRC_CNT_W-1:0] dut_cnt;
    string cnt_name [11] = '{"bmisp", "brmisp", "jmisp", "jrmisp", "fmisp", "loads", "stores",
                             "icmiss", "dcmiss", "itmiss", "dtmiss"};
    int seed = 32'h1d608d63;
    int errors = 0;
    int tests = 0;

    commit_monitor commit_monitor_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [63:0] rand64();
        return {rand32(), rand32()};
    endfunction

    // machine address of a CSR write
    function automatic logic [11:0] machine_csr(logic [11:0] a);
        case (a)
            12'h100: return 12'h300;
            12'h104: return 12'h304;
            12'h144: return 12'h344;
            12'hc00: return 12'hb00;
            12'hc01: return 12'hb01;
            12'hc02: return 12'hb02;
            default: return a;
        endcase
    endfunction

    function automatic int low_byte(logic [`TRC_STRB_W-1:0] s);
        for (int i = 0; i < `TRC_STRB_W; i++) begin
            if (s[i]) return i;
        end
        return 0;
    endfunction

    function automatic logic [3:0] byte_count(logic [`TRC_STRB_W-1:0] s);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < `TRC_STRB_W; i++) begin
            if (s[i]) n = n + 4'd1;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_trc_valid = 1'b0;
            exp_csrw = 1'b0;
            exp_mem_evt = 1'b0;
            exp_memw = 4'd0;
            exp_cnt = '0;
        end else begin
            exp_trc_valid = cmt_valid;
            if (cmt_valid) begin
                exp_pc = cmt_pc;
                exp_ir = cmt_ir;
                exp_snap = snap_mdl[cmt_opid];
            end
            exp_csrw = csr_we;
            if (csr_we) begin
                exp_csra = machine_csr(csr_addr);
                exp_csrv = csr_wdata;
            end
            exp_mem_evt = dc_resp_valid && dc_resp_store && !dc_resp_miss;
            exp_memw = exp_mem_evt ? rec_size[dc_resp_tag] : 4'd0;
            if (exp_mem_evt) begin
                exp_mema = rec_addr[dc_resp_tag];
                exp_memv = rec_data[dc_resp_tag];
            end
            if (mis_valid) begin
                exp_cnt[0] += 1;
                case (mis_kind)
                    2'd0: exp_cnt[1] += 1;
                    2'd1: exp_cnt[2] += 1;
                    default: exp_cnt[3] += 1;
                endcase
            end
            if (fe_redir && !mis_valid) exp_cnt[4] += 1;    // flush hides the redirect
            if (dc_resp_valid && !dc_resp_store) exp_cnt[5] += 1;
            if (dc_resp_valid && dc_resp_store) exp_cnt[6] += 1;
            if (ic_miss) exp_cnt[7] += 1;
            if (dc_miss) exp_cnt[8] += 1;
            if (itlb_fill) exp_cnt[9] += 1;
            if (dtlb_fill) exp_cnt[10] += 1;
        end
        // tables written after this cycle's lookups
        if (dec_valid) snap_mdl[dec_opid] = '{dec_mstatus, dec_mtvec, dec_mepc, dec_mcause};
        if (dc_rqst_valid) begin
            rec_addr[dc_rqst_tag] = dc_addr;
            rec_data[dc_rqst_tag] = dc_wdat >> (8 * low_byte(dc_strb));
            rec_size[dc_rqst_tag] = byte_count(dc_strb);
        end
    end

    task automatic report_mismatch(string name, logic [63:0] exp_val, logic [63:0] act_val);
        $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, exp_val, act_val, $time);
        errors++;
    endtask

    assign dut_cnt = {dtmiss, itmiss, dcmiss, icmiss, stores, loads, fmisp, jrmisp, jmisp,
                      brmisp, bmisp};

    a_trc_valid: assert property (@(negedge clk) disable iff (rst) trc_valid == exp_trc_valid)
        else report_mismatch("trc_valid", 64'(exp_trc_valid), 64'(trc_valid));
    a_trc_pc: assert property (@(negedge clk) disable iff (rst) exp_trc_valid |-> trc_pc == exp_pc)
        else report_mismatch("trc_pc", exp_pc, trc_pc);
    a_trc_ir: assert property (@(negedge clk) disable iff (rst) exp_trc_valid |-> trc_ir == exp_ir)
        else report_mismatch("trc_ir", 64'(exp_ir), 64'(trc_ir));
    a_mstatus: assert property (@(negedge clk) disable iff (rst)
        exp_trc_valid |-> trc_mstatus == exp_snap.mstatus)
        else report_mismatch("trc_mstatus", exp_snap.mstatus, trc_mstatus);
    a_mtvec: assert property (@(negedge clk) disable iff (rst)
        exp_trc_valid |-> trc_mtvec == exp_snap.mtvec)
        else report_mismatch("trc_mtvec", exp_snap.mtvec, trc_mtvec);
    a_mepc: assert property (@(negedge clk) disable iff (rst)
        exp_trc_valid |-> trc_mepc == exp_snap.mepc)
        else report_mismatch("trc_mepc", exp_snap.mepc, trc_mepc);
    a_mcause: assert property (@(negedge clk) disable iff (rst)
        exp_trc_valid |-> trc_mcause == exp_snap.mcause)
        else report_mismatch("trc_mcause", exp_snap.mcause, trc_mcause);
    a_csrw: assert property (@(negedge clk) disable iff (rst) del_csrw == exp_csrw)
        else report_mismatch("del_csrw", 64'(exp_csrw), 64'(del_csrw));
    a_csra: assert property (@(negedge clk) disable iff (rst) exp_csrw |-> del_csra == exp_csra)
        else report_mismatch("del_csra", 64'(exp_csra), 64'(del_csra));
    a_csrv: assert property (@(negedge clk) disable iff (rst) exp_csrw |-> del_csrv == exp_csrv)
        else report_mismatch("del_csrv", exp_csrv, del_csrv);
    a_memw: assert property (@(negedge clk) disable iff (rst) del_memw == exp_memw)
        else report_mismatch("del_memw", 64'(exp_memw), 64'(del_memw));
    a_mema: assert property (@(negedge clk) disable iff (rst) exp_mem_evt |-> del_mema == exp_mema)
        else report_mismatch("del_mema", exp_mema, del_mema);
    a_memv: assert property (@(negedge clk) disable iff (rst) exp_mem_evt |-> del_memv == exp_memv)
        else report_mismatch("del_memv", exp_memv, del_memv);
    a_kinds: assert property (@(negedge clk) disable iff (rst) brmisp + jmisp + jrmisp == bmisp)
        else begin
            $display("misprediction kinds do not add up to bmisp at %0t", $time);
            errors++;
        end

    for (genvar g = 0; g < 11; g++) begin : g_cnt_chk
        a_cnt: assert property (@(negedge clk) disable iff (rst) dut_cnt[g] == exp_cnt[g])
            else report_mismatch(cnt_name[g], 64'(exp_cnt[g]), 64'(dut_cnt[g]));
    end

    task automatic clear_strobes();
        dec_valid = 1'b0;
        cmt_valid = 1'b0;
        csr_we = 1'b0;
        dc_rqst_valid = 1'b0;
        dc_resp_valid = 1'b0;
        mis_valid = 1'b0;
        fe_redir = 1'b0;
        ic_miss = 1'b0;
        dc_miss = 1'b0;
        itlb_fill = 1'b0;
        dtlb_fill = 1'b0;
    endtask

    task automatic randomize_payload();
        logic [63:0] r;
        r = rand64();
        dec_opid = r[3:0];
        cmt_opid = r[7:4];
        csr_addr = r[19:8];
        dc_rqst_tag = r[22:20];
        dc_resp_tag = r[25:23];
        dc_strb = r[33:26];
        mis_kind = r[35:34];
        dc_resp_store = r[36];
        dc_resp_miss = r[37];
        cmt_ir = r[63:32];
        dec_mstatus = rand64();
        dec_mtvec = rand64();
        dec_mepc = rand64();
        dec_mcause = rand64();
        cmt_pc = rand64();
        csr_wdata = rand64();
        dc_addr = rand64();
        dc_wdat = rand64();
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_strobes();
        randomize_payload();
    endtask

    task automatic close_test(string name, int err_before);
        next_cycle();
        next_cycle();    // last strobe gets checked
        tests++;
        $display("test %s: %s, %0d errors", name, errors == err_before ? "ok" : "mismatches",
                 errors - err_before);
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = errors;
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        close_test("reset", err0);
    endtask

    task automatic replay_snapshots();
        logic [`TRC_OPID_W-1:0] ids [`TRC_ROB_DEPTH];
        logic [`TRC_OPID_W-1:0] tmp;
        int j;
        int err0;
        err0 = errors;
        for (int i = 0; i < `TRC_ROB_DEPTH; i++) ids[i] = `TRC_OPID_W'(i);
        for (int i = 0; i < `TRC_ROB_DEPTH; i++) begin    // shuffle the ids
            j = int'(rand32() % 32'd16);
            tmp = ids[i];
            ids[i] = ids[j];
            ids[j] = tmp;
        end
        for (int i = 0; i < N_SNAP; i++) begin
            dec_valid = 1'b1;
            dec_opid = ids[i];
            next_cycle();
        end
        for (int i = N_SNAP - 1; i >= 0; i--) begin    // commit in reverse order
            cmt_valid = 1'b1;
            cmt_opid = ids[i];
            next_cycle();
        end
        close_test("snapshots", err0);
    endtask

    task automatic normalise_csr_writes();
        int err0;
        err0 = errors;
        for (int i = 0; i < N_CSR; i++) begin
            csr_we = 1'b1;
            csr_addr = CSR_LIST[i];
            next_cycle();
        end
        close_test("csr", err0);
    endtask

    task automatic track_stores();
        logic [`TRC_TAG_W-1:0] tag;
        int err0;
        err0 = errors;
        for (int i = 0; i < N_MEM; i++) begin
            tag = `TRC_TAG_W'(i);
            dc_rqst_valid = 1'b1;
            dc_rqst_tag = tag;
            if (dc_strb == '0) dc_strb = 8'h01;
            next_cycle();
            if (i % 3 == 2) begin    // missed store, replayed next cycle
                dc_resp_valid = 1'b1;
                dc_resp_tag = tag;
                dc_resp_store = 1'b1;
                dc_resp_miss = 1'b1;
                next_cycle();
            end
            dc_resp_valid = 1'b1;
            dc_resp_tag = tag;
            dc_resp_store = (i % 3 != 1);    // every third one a load
            dc_resp_miss = 1'b0;
            next_cycle();
        end
        close_test("stores", err0);
    endtask

    task automatic count_events();
        logic [31:0] r;
        int err0;
        err0 = errors;
        for (int i = 0; i < N_PERF; i++) begin
            r = rand32();
            mis_valid = r[0];
            mis_kind = r[2:1] % 2'd3;
            fe_redir = r[3];
            ic_miss = r[4];
            dc_miss = r[5];
            itlb_fill = r[6];
            dtlb_fill = r[7];
            dc_rqst_valid = 1'b1;
            dc_rqst_tag = `TRC_TAG_W'(i);
            dc_resp_valid = (i > 0) && r[8];    // answers the previous request
            dc_resp_tag = `TRC_TAG_W'(i - 1);
            dc_resp_store = r[9];
            dc_resp_miss = r[10];
            next_cycle();
        end
        close_test("counters", err0);
    endtask

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        clear_strobes();
        randomize_payload();
        check_reset_state();
        replay_snapshots();
        normalise_csr_writes();
        track_stores();
        count_events();
        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: commit_monitor.f
+incdir+.
perf_pkg.sv
trace_pkg.sv
mem_evt_if.sv
csr_snap_table.sv
store_tracker.sv
commit_trace.sv
perf_counters.sv
commit_monitor.sv
commit_monitor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the commit monitor testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module commit_monitor_tb -f commit_monitor.f \
        --Mdir obj_dir -o commit_monitor_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/commit_monitor_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
